/* src/tl_pkg.sv */
// Host bus definitions.
// Reduced TileLink-UL style channel pair: A channel carries requests,
// D channel carries responses, each with its own valid/ready pair.
package tl_pkg;

  // Bus widths.
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int MaskWidth = DataWidth / 8;

  // Low address bits that select a byte inside one bus word.
  localparam int ByteOffsetWidth = $clog2(MaskWidth);

  // Responses one steering target may owe the host at once.
  localparam int MaxOutstanding = 2;
  localparam int CntWidth       = $clog2(MaxOutstanding + 1);

  typedef logic [AddrWidth-1:0] tl_addr_t;
  typedef logic [DataWidth-1:0] tl_data_t;
  typedef logic [MaskWidth-1:0] tl_mask_t;

  // A-channel opcodes, encoded as in TL-UL.
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_opcode_e;

  // Host to device.
  typedef struct packed {
    logic       a_valid;
    tl_opcode_e a_opcode;
    tl_addr_t   a_address;
    tl_data_t   a_data;
    tl_mask_t   a_mask;
    logic       d_ready;
  } tl_h2d_t;

  // Device to host.
  typedef struct packed {
    logic     a_ready;
    logic     d_valid;
    logic     d_is_read;
    tl_data_t d_data;
    logic     d_error;
  } tl_d2h_t;

endpackage

/* src/sim_sram_pkg.sv */
// Simulation SRAM definitions.
// Memory geometry, the address window and the APB configuration port types.
package sim_sram_pkg;

  // Memory geometry.
  localparam int SramDepth     = 64;
  localparam int SramAddrWidth = $clog2(SramDepth);

  // Window that maps onto the SRAM, in bytes.
  localparam int WindowBytes = 256;
  localparam tl_pkg::tl_addr_t StartAddrReset = 32'h1000_0000;

  typedef logic [SramAddrWidth-1:0] sram_addr_t;

  // APB configuration port.
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Register offset of START.
  localparam apb_addr_t StartRegAddr = 8'h00;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

endpackage

/* src/sim_sram_window.sv */
// SRAM address window.
// Holds the window start address, written and read back over APB,
// and flags bus addresses that fall inside the window.
module sim_sram_window (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  sim_sram_pkg::apb_req_t cfg_req_i,
  output sim_sram_pkg::apb_rsp_t cfg_rsp_o,
  input  tl_pkg::tl_addr_t       addr_i,
  output logic                   in_window_o
);

  tl_pkg::tl_addr_t start_q;
  tl_pkg::tl_addr_t offset;
  logic             reg_hit;
  logic             access;

  // Only one register is mapped.
  assign reg_hit = cfg_req_i.paddr == sim_sram_pkg::StartRegAddr;

  // Access phase of an APB transfer.
  assign access = cfg_req_i.psel & cfg_req_i.penable;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= sim_sram_pkg::StartAddrReset;
    end else if (access && cfg_req_i.pwrite && reg_hit) begin
      start_q <= cfg_req_i.pwdata;
    end
  end

  always_comb begin
    // Always ready, so every transfer ends in its access phase.
    cfg_rsp_o.pready = 1'b1;
    // Unmapped addresses read as zero.
    cfg_rsp_o.prdata = '0;
    if (cfg_req_i.psel && !cfg_req_i.pwrite && reg_hit) begin
      cfg_rsp_o.prdata = start_q;
    end
    cfg_rsp_o.pslverr = cfg_req_i.psel & ~reg_hit;
  end

  // Distance from the window start.
  // Wraps for addresses below START, which the first term filters out.
  assign offset = addr_i - start_q;

  assign in_window_o = (addr_i >= start_q) &&
                       (offset < tl_pkg::tl_addr_t'(sim_sram_pkg::WindowBytes));

  // Access phase must follow a setup phase of the same transfer.
  PenableNeedsPsel_A : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(cfg_req_i.penable) |-> cfg_req_i.psel && $past(cfg_req_i.psel)
  );

endmodule

/* src/tl_steer_1to2.sv */
// Address steering from one host to two devices.
// Port 0 is the outbound bus, port 1 the local SRAM. Responses come back in
// request order because the host stalls whenever the target would change.
module tl_steer_1to2 (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            in_window_i,
  input  tl_pkg::tl_h2d_t tl_h_i,
  output tl_pkg::tl_d2h_t tl_h_o,
  output tl_pkg::tl_h2d_t tl_out_o,
  input  tl_pkg::tl_d2h_t tl_out_i,
  output tl_pkg::tl_h2d_t tl_sram_o,
  input  tl_pkg::tl_d2h_t tl_sram_i
);

  // Outstanding responses and the target that owes them.
  logic [tl_pkg::CntWidth-1:0] cnt_q;
  logic                        tgt_sram_q;

  logic            due_sram;
  logic            stall;
  logic            tgt_ready;
  logic            req_take;
  logic            rsp_take;
  tl_pkg::tl_d2h_t tl_due;

  // With nothing outstanding, a zero-latency reply can only come from the
  // target of the current request.
  assign due_sram = (cnt_q == '0) ? in_window_i : tgt_sram_q;

  // Hold the host while older responses from the other target are owed,
  // or when the counter is full.
  assign stall = ((cnt_q != '0) && (tgt_sram_q != in_window_i)) ||
                 (cnt_q == tl_pkg::CntWidth'(tl_pkg::MaxOutstanding));

  assign tgt_ready = in_window_i ? tl_sram_i.a_ready : tl_out_i.a_ready;
  assign tl_due    = due_sram ? tl_sram_i : tl_out_i;

  always_comb begin
    // Request fields fan out to both sides, valid goes to one only.
    tl_out_o         = tl_h_i;
    tl_out_o.a_valid = tl_h_i.a_valid & ~in_window_i & ~stall;
    tl_out_o.d_ready = tl_h_i.d_ready & ~due_sram;

    tl_sram_o         = tl_h_i;
    tl_sram_o.a_valid = tl_h_i.a_valid & in_window_i & ~stall;
    tl_sram_o.d_ready = tl_h_i.d_ready & due_sram;

    // Response comes from the target whose turn it is.
    tl_h_o         = tl_due;
    tl_h_o.a_ready = tgt_ready & ~stall;
  end

  assign req_take = tl_h_i.a_valid & tl_h_o.a_ready;
  assign rsp_take = tl_h_o.d_valid & tl_h_i.d_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      tgt_sram_q <= 1'b0;
    end else begin
      // Count up on request, down on response, hold when both happen.
      if (req_take && !rsp_take) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!req_take && rsp_take) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // Target only changes when nothing is owed, so a plain update works.
      if (req_take) begin
        tgt_sram_q <= in_window_i;
      end
    end
  end

  // Only one device may present a response at a time.
  OneResponder_A : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(tl_out_i.d_valid && tl_sram_i.d_valid)
  );

  // Counter stays within its limit.
  CntBound_A : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= tl_pkg::CntWidth'(tl_pkg::MaxOutstanding)
  );

endmodule

/* src/tl_sram_adapter.sv */
// Bus to SRAM adapter.
// Turns each accepted request into one SRAM access and keeps a single
// response until the host takes it.
module tl_sram_adapter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  tl_pkg::tl_h2d_t          tl_i,
  output tl_pkg::tl_d2h_t          tl_o,
  output logic                     req_o,
  output logic                     we_o,
  output sim_sram_pkg::sram_addr_t addr_o,
  output tl_pkg::tl_data_t         wdata_o,
  output tl_pkg::tl_mask_t         wmask_o,
  input  tl_pkg::tl_data_t         rdata_i
);

  // Pending response state.
  logic pend_q;
  logic pend_read_q;
  logic pend_err_q;
  // Read data arrives from the SRAM in this cycle.
  logic rd_fresh_q;

  tl_pkg::tl_data_t rdata_q;
  logic             misaligned;
  logic             req_take;
  logic             rsp_take;

  assign misaligned = tl_i.a_address[tl_pkg::ByteOffsetWidth-1:0] != '0;
  assign req_take   = tl_i.a_valid & ~pend_q;
  assign rsp_take   = pend_q & tl_i.d_ready;

  // Misaligned requests get an error and never touch the memory.
  assign req_o   = req_take & ~misaligned;
  assign we_o    = tl_i.a_opcode != tl_pkg::Get;
  assign addr_o  = tl_i.a_address[tl_pkg::ByteOffsetWidth +: sim_sram_pkg::SramAddrWidth];
  assign wdata_o = tl_i.a_data;
  // Full writes ignore the mask from the host.
  assign wmask_o = (tl_i.a_opcode == tl_pkg::PutFullData) ? '1 : tl_i.a_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      pend_read_q <= 1'b0;
      pend_err_q  <= 1'b0;
      rd_fresh_q  <= 1'b0;
    end else begin
      rd_fresh_q <= req_o & ~we_o;
      if (req_take) begin
        pend_q      <= 1'b1;
        pend_read_q <= tl_i.a_opcode == tl_pkg::Get;
        pend_err_q  <= misaligned;
      end else if (rsp_take) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Keep read data for as long as the host holds off.
  always_ff @(posedge clk_i) begin
    if (rd_fresh_q) begin
      rdata_q <= rdata_i;
    end
  end

  always_comb begin
    tl_o.a_ready   = ~pend_q;
    tl_o.d_valid   = pend_q;
    tl_o.d_is_read = pend_read_q;
    tl_o.d_error   = pend_err_q;
    tl_o.d_data    = '0;
    if (pend_read_q && !pend_err_q) begin
      tl_o.d_data = rd_fresh_q ? rdata_i : rdata_q;
    end
  end

  NoReqWhilePending_A : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pend_q |-> !req_o
  );

  // Response is held unchanged under back-pressure.
  RspStable_A : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tl_o.d_valid && !tl_i.d_ready |=> tl_o.d_valid && $stable(tl_o.d_data)
  );

endmodule

/* src/sram_1p.sv */
// Single-port SRAM model.
// Byte-maskable writes, reads registered with one cycle of latency.
module sram_1p (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  sim_sram_pkg::sram_addr_t addr_i,
  input  tl_pkg::tl_data_t         wdata_i,
  input  tl_pkg::tl_mask_t         wmask_i,
  output tl_pkg::tl_data_t         rdata_o
);

  tl_pkg::tl_data_t mem [sim_sram_pkg::SramDepth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Update only the enabled bytes.
        for (int b = 0; b < tl_pkg::MaskWidth; b++) begin
          if (wmask_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* src/sim_sram_top.sv */
// Simulation SRAM bus tap.
// Requests inside the configurable window go to a local SRAM,
// everything else passes through to the outbound bus.
module sim_sram_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tl_pkg::tl_h2d_t        tl_in_i,
  output tl_pkg::tl_d2h_t        tl_in_o,
  output tl_pkg::tl_h2d_t        tl_out_o,
  input  tl_pkg::tl_d2h_t        tl_out_i,
  input  sim_sram_pkg::apb_req_t cfg_req_i,
  output sim_sram_pkg::apb_rsp_t cfg_rsp_o
);

  logic                     in_window;
  tl_pkg::tl_h2d_t          tl_sram_h2d;
  tl_pkg::tl_d2h_t          tl_sram_d2h;

  // SRAM port.
  logic                     sram_req;
  logic                     sram_we;
  sim_sram_pkg::sram_addr_t sram_addr;
  tl_pkg::tl_data_t         sram_wdata;
  tl_pkg::tl_mask_t         sram_wmask;
  tl_pkg::tl_data_t         sram_rdata;

  // Window decode on the host address.
  sim_sram_window u_window (
    .clk_i,
    .rst_ni,
    .cfg_req_i,
    .cfg_rsp_o,
    .addr_i     (tl_in_i.a_address),
    .in_window_o(in_window)
  );

  tl_steer_1to2 u_steer (
    .clk_i,
    .rst_ni,
    .in_window_i(in_window),
    .tl_h_i     (tl_in_i),
    .tl_h_o     (tl_in_o),
    .tl_out_o,
    .tl_out_i,
    .tl_sram_o  (tl_sram_h2d),
    .tl_sram_i  (tl_sram_d2h)
  );

  tl_sram_adapter u_adapter (
    .clk_i,
    .rst_ni,
    .tl_i   (tl_sram_h2d),
    .tl_o   (tl_sram_d2h),
    .req_o  (sram_req),
    .we_o   (sram_we),
    .addr_o (sram_addr),
    .wdata_o(sram_wdata),
    .wmask_o(sram_wmask),
    .rdata_i(sram_rdata)
  );

  sram_1p u_sram (
    .clk_i,
    .req_i  (sram_req),
    .we_i   (sram_we),
    .addr_i (sram_addr),
    .wdata_i(sram_wdata),
    .wmask_i(sram_wmask),
    .rdata_o(sram_rdata)
  );

endmodule

/* testbench/tb_sim_sram.sv */
// Testbench for the simulation SRAM bus tap.
// Runs the cases file through the host bus and the APB port, models the
// outbound device and checks every response in request order.
module tb_sim_sram;

  localparam int ClkPeriod = 40;

  // One line of the cases file.
  typedef struct packed {
    logic [31:0]      kind;
    tl_pkg::tl_addr_t addr;
    tl_pkg::tl_data_t data;
    tl_pkg::tl_mask_t mask;
    tl_pkg::tl_data_t exp;
    logic             err;
    logic             sram;
  } case_t;

  // Response still owed to the host, tagged with its case.
  typedef struct packed {
    int    idx;
    case_t c;
  } owed_t;

  logic                   clk_i;
  logic                   rst_ni;
  tl_pkg::tl_h2d_t        host_req;
  tl_pkg::tl_d2h_t        host_rsp;
  tl_pkg::tl_h2d_t        out_req;
  tl_pkg::tl_d2h_t        out_rsp;
  sim_sram_pkg::apb_req_t cfg_req;
  sim_sram_pkg::apb_rsp_t cfg_rsp;

  case_t            cases[$];
  owed_t            owed_q[$];
  tl_pkg::tl_addr_t out_log[$];
  int               err_cnt = 0;
  int               n_pass = 0;
  int               n_fail = 0;
  int               n_cases = 0;
  logic [31:0]      lfsr_q = 32'ha69f;

  sim_sram_top dut (
    .clk_i,
    .rst_ni,
    .tl_in_i  (host_req),
    .tl_in_o  (host_rsp),
    .tl_out_o (out_req),
    .tl_out_i (out_rsp),
    .cfg_req_i(cfg_req),
    .cfg_rsp_o(cfg_rsp)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic check_data(input string name, input tl_pkg::tl_data_t exp,
                            input tl_pkg::tl_data_t got);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_addr(input string name, input tl_pkg::tl_addr_t exp,
                            input tl_pkg::tl_addr_t got);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s exp %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic report_test(input int idx, input int errs_before);
    if (err_cnt == errs_before) begin
      n_pass++;
      $display("test %0d %0s ok", idx, cases[idx].kind);
    end else begin
      n_fail++;
      $display("test %0d %0s failed", idx, cases[idx].kind);
    end
  endtask

  task automatic load_cases();
    int               fd;
    string            line;
    logic [31:0]      kind;
    tl_pkg::tl_addr_t addr;
    tl_pkg::tl_data_t data;
    tl_pkg::tl_data_t exp;
    logic [3:0]       mask;
    logic             err;
    logic             sram;
    fd = $fopen("testbench/sim_sram_cases.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("Could not open the cases file.");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Comment and blank lines hold no case.
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%s %h %h %h %h %h %h", kind, addr, data, mask, exp, err,
                      sram) == 7) begin
            cases.push_back('{kind, addr, data, mask, exp, err, sram});
          end else begin
            err_cnt++;
            $display("Malformed line in the cases file: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (cases.size() == 0) begin
      err_cnt++;
      $display("No cases were loaded.");
    end
    n_cases = cases.size();
  endtask

  // Puts one request on the A channel and holds it until it is taken.
  task automatic send_req(input int idx);
    owed_t o;
    o.idx = idx;
    o.c   = cases[idx];
    #5;
    owed_q.push_back(o);
    host_req.a_valid   = 1'b1;
    host_req.a_address = o.c.addr;
    host_req.a_data    = o.c.data;
    host_req.a_mask    = o.c.mask;
    if (o.c.kind == "RD") begin
      host_req.a_opcode = tl_pkg::Get;
    end else begin
      host_req.a_opcode = (o.c.mask == 4'hf) ? tl_pkg::PutFullData : tl_pkg::PutPartialData;
    end
    do begin
      @(posedge clk_i);
    end while (!host_rsp.a_ready);
  endtask

  // Idles the A channel until every owed response is back.
  task automatic drain_bus();
    #5;
    host_req.a_valid = 1'b0;
    while (owed_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
  endtask

  // One APB transfer, setup then access phase.
  task automatic apb_access(input int idx);
    int    e0;
    case_t c;
    c  = cases[idx];
    e0 = err_cnt;
    #5;
    cfg_req.psel   = 1'b1;
    cfg_req.pwrite = c.kind == "CFGW";
    cfg_req.paddr  = c.addr[7:0];
    cfg_req.pwdata = c.data;
    @(posedge clk_i);
    #5;
    cfg_req.penable = 1'b1;
    @(posedge clk_i);
    if (!cfg_rsp.pready) begin
      err_cnt++;
      $display("APB transfer did not complete in its access phase.");
    end
    if (c.kind == "CFGR") begin
      check_data("prdata", c.exp, cfg_rsp.prdata);
    end
    check_err("pslverr", c.err, cfg_rsp.pslverr);
    #5;
    cfg_req.psel    = 1'b0;
    cfg_req.penable = 1'b0;
    report_test(idx, e0);
    @(posedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Outbound device: takes a request when idle, answers on the next edge.
  initial begin : out_model
    logic            take_req;
    logic            take_rsp;
    tl_pkg::tl_h2d_t seen;
    out_rsp         = '0;
    out_rsp.a_ready = 1'b1;
    forever begin
      @(posedge clk_i);
      take_req = out_req.a_valid & out_rsp.a_ready;
      take_rsp = out_rsp.d_valid & out_req.d_ready;
      seen     = out_req;
      #5;
      if (take_rsp) begin
        out_rsp.d_valid = 1'b0;
      end
      if (take_req) begin
        out_log.push_back(seen.a_address);
        out_rsp.d_valid   = 1'b1;
        out_rsp.d_is_read = seen.a_opcode == tl_pkg::Get;
        out_rsp.d_data    = out_rsp.d_is_read ? (seen.a_address ^ 32'h5a5a_5a5a) : '0;
      end
      out_rsp.a_ready = ~out_rsp.d_valid;
    end
  end

  // D channel checker; d_ready pauses come from the LFSR.
  initial begin : rsp_monitor
    owed_t o;
    int    e0;
    int    pause_left;
    pause_left = 0;
    forever begin
      @(posedge clk_i);
      if (host_rsp.d_valid && host_req.d_ready) begin
        if (owed_q.size() == 0) begin
          err_cnt++;
          $display("Response arrived with no request outstanding.");
        end else begin
          o  = owed_q.pop_front();
          e0 = err_cnt;
          check_err("d_error", o.c.err, host_rsp.d_error);
          check_err("d_is_read", o.c.kind == "RD", host_rsp.d_is_read);
          if (o.c.kind == "RD" && !o.c.err) begin
            check_data("d_data", o.c.exp, host_rsp.d_data);
          end
          // SRAM hits never show up on the outbound bus.
          if (o.c.sram && out_log.size() != 0) begin
            err_cnt++;
            $display("Outbound bus saw a request that belongs to the SRAM.");
          end else if (!o.c.sram && out_log.size() == 0) begin
            err_cnt++;
            $display("Outbound bus never saw the request.");
          end else if (!o.c.sram) begin
            check_addr("out a_address", o.c.addr, out_log.pop_front());
          end
          report_test(o.idx, e0);
        end
      end
      #5;
      if (pause_left > 0) begin
        pause_left--;
      end else if (lfsr_bit() && lfsr_bit()) begin
        pause_left = 1 + 2 * lfsr_bit() + lfsr_bit();
      end
      host_req.d_ready = pause_left == 0;
    end
  end

  initial begin : watchdog
    wait (n_cases != 0);
    #((n_cases * 50 + 8) * ClkPeriod);
    $display("Watchdog expired before all cases finished.");
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    rst_ni   = 1'b0;
    host_req = '0;
    cfg_req  = '0;
    load_cases();
    repeat (8) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    @(posedge clk_i);
    // Bus cases run back to back; APB cases wait for the bus to settle.
    for (int i = 0; i < n_cases; i++) begin
      if (cases[i].kind == "WR" || cases[i].kind == "RD") begin
        send_req(i);
      end else begin
        drain_bus();
        apb_access(i);
      end
    end
    drain_bus();
    $display("tests %0d passed %0d failed %0d errors %0d", n_cases, n_pass, n_fail, err_cnt);
    if (err_cnt == 0 && n_pass == n_cases) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* testbench/sim_sram_cases.txt */
# kind addr data mask expected err sram, all fields hex
# sram is 1 when the access should land in the local SRAM
CFGR 00 0 0 10000000 0 0
WR 10000000 11223344 f 0 0 1
RD 10000000 0 0 11223344 0 1
WR 10000004 aabbccdd f 0 0 1
WR 10000004 00ee0022 5 0 0 1
RD 10000004 0 0 aaeecc22 0 1
RD 20000010 0 0 7a5a5a4a 0 0
WR 10000100 deadbeef f 0 0 0
RD 10000000 0 0 11223344 0 1
WR 10000008 12345678 f 0 0 1
RD 30000000 0 0 6a5a5a5a 0 0
RD 10000008 0 0 12345678 0 1
RD 10000004 0 0 aaeecc22 0 1
RD 30000004 0 0 6a5a5a5e 0 0
RD 40000008 0 0 1a5a5a52 0 0
RD 10000002 0 0 0 1 1
WR 10000009 ffffffff f 0 1 1
RD 10000008 0 0 12345678 0 1
CFGW 00 20000000 0 0 0 0
CFGR 00 0 0 20000000 0 0
CFGR 04 0 0 0 1 0
RD 10000000 0 0 4a5a5a5a 0 0
RD 20000000 0 0 11223344 0 1
RD 20000100 0 0 7a5a5b5a 0 0

/* flist.f */
src/tl_pkg.sv
src/sim_sram_pkg.sv
src/sim_sram_window.sv
src/tl_steer_1to2.sv
src/tl_sram_adapter.sv
src/sram_1p.sv
src/sim_sram_top.sv
testbench/tb_sim_sram.sv

/* Bender.yml */
package:
  name: sim_sram

sources:
  - target: any(rtl, test)
    files:
      - src/tl_pkg.sv
      - src/sim_sram_pkg.sv
      - src/sim_sram_window.sv
      - src/tl_steer_1to2.sv
      - src/tl_sram_adapter.sv
      - src/sram_1p.sv
      - src/sim_sram_top.sv

  - target: test
    files:
      - testbench/tb_sim_sram.sv
